// File: Makefile
# Verilator build and run of the video timing testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_video_timing
FILELIST := files.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) verification/tb_tasks.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+verification
source/video_timing_pkg.sv
source/cpu_bus_pkg.sv
source/h_timing.sv
source/v_timing.sv
source/timing_regs.sv
source/video_timing_top.sv
verification/tb_video_timing.sv

// File: source/cpu_bus_pkg.sv
package cpu_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// wishbone widths
	////////////////////////////////////////////////////////////////////////////

	// 16 bit data, word addressed
	localparam int BUS_DATA_W = 16;
	// four registers only
	localparam int BUS_ADDR_W = 2;

	typedef logic [BUS_DATA_W-1:0] bus_data_t;
	typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////////////////////

	// bit 0 irq enable
	localparam bus_addr_t REG_CONTROL = 2'd0;
	// bit 0 vblank pending, write 1 to clear
	localparam bus_addr_t REG_STATUS = 2'd1;
	// current line, read only
	localparam bus_addr_t REG_POSITION = 2'd2;
	// frame count, read only
	localparam bus_addr_t REG_FRAME = 2'd3;

endpackage

// File: source/h_timing.sv
`timescale 1ns/1ps

module h_timing #(
	parameter int H_PRELOAD = video_timing_pkg::H_PRELOAD,
	parameter int H_VISIBLE_FIRST = video_timing_pkg::H_VISIBLE_FIRST,
	parameter int H_VISIBLE_LAST = video_timing_pkg::H_VISIBLE_LAST,
	parameter int H_SYNC_FIRST = video_timing_pkg::H_SYNC_FIRST,
	parameter int H_SYNC_LAST = video_timing_pkg::H_SYNC_LAST
) (
	input logic CLK_6M_IN,
	input logic rst_n,

	// beam position
	output video_timing_pkg::h_count_t h_count,

	// line events for the vertical side
	output logic line_start,
	output logic line_end,

	// active low video timing
	output logic hblank_n,
	output logic hsync_n,
	output logic hreset_n,

	// pixel phase strobes
	output logic strobe_1h,
	output logic strobe_2h,
	output logic strobe_4h
);

	// terminal count of the chain, the carry that feeds hreset
	localparam video_timing_pkg::h_count_t H_LAST = '1;

	logic at_last;
	logic h_visible;
	logic h_sync;

	////////////////////////////////////////////////////////////////////////////
	// counter chain
	////////////////////////////////////////////////////////////////////////////

	assign at_last = (h_count == H_LAST);

	// synchronous load on carry, like the '161 pair
	always_ff @(posedge CLK_6M_IN or negedge rst_n) begin
		if (!rst_n) begin
			h_count <= video_timing_pkg::h_count_t'(H_PRELOAD);
		end else if (at_last) begin
			h_count <= video_timing_pkg::h_count_t'(H_PRELOAD);
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// decodes, same edge as the count
	////////////////////////////////////////////////////////////////////////////

	// visible window and sync window
	assign h_visible = (h_count >= H_VISIBLE_FIRST) && (h_count <= H_VISIBLE_LAST);
	assign h_sync = (h_count >= H_SYNC_FIRST) && (h_count <= H_SYNC_LAST);

	assign hblank_n = h_visible;
	assign hsync_n = !h_sync;
	// low for the one clock at 511
	assign hreset_n = !at_last;

	// last clock of the line and first clock after reload
	assign line_end = at_last;
	assign line_start = (h_count == H_PRELOAD);

	// phase pulses off the low three bits, one clock each per 8
	assign strobe_1h = (h_count[2:0] == 3'd1);
	assign strobe_2h = (h_count[2:0] == 3'd2);
	assign strobe_4h = (h_count[2:0] == 3'd4);

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// preload region is never entered
	a_h_above_preload: assert property (@(posedge CLK_6M_IN) disable iff (!rst_n)
		h_count >= H_PRELOAD)
		else $error("h_count fell below the preload value");

	// reload must take effect, one carry per line
	a_line_end_single: assert property (@(posedge CLK_6M_IN) disable iff (!rst_n)
		line_end |=> !line_end)
		else $error("line_end high on two consecutive clocks");

endmodule

// File: source/timing_regs.sv
`timescale 1ns/1ps

module timing_regs (
	input logic CLK_6M_IN,
	input logic rst_n,

	// wishbone classic slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input cpu_bus_pkg::bus_addr_t wb_adr,
	input cpu_bus_pkg::bus_data_t wb_dat_w,
	output cpu_bus_pkg::bus_data_t wb_dat_r,
	output logic wb_ack,

	// from the raster
	input video_timing_pkg::v_count_t v_count,
	input logic vblank_start,
	input logic frame_end,

	// vblank interrupt to the cpu
	output logic irq
);

	logic req;
	logic take;
	logic wr;
	logic irq_enable;
	logic irq_pending;
	cpu_bus_pkg::bus_data_t frame_count;
	cpu_bus_pkg::bus_data_t rd_mux;

	////////////////////////////////////////////////////////////////////////////
	// bus handshake
	////////////////////////////////////////////////////////////////////////////

	assign req = wb_cyc && wb_stb;
	// accept only when not acking, so a held request gets every other clock
	assign take = req && !wb_ack;
	assign wr = take && wb_we;

	always_ff @(posedge CLK_6M_IN or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= take;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	// control bit 0
	always_ff @(posedge CLK_6M_IN or negedge rst_n) begin
		if (!rst_n) begin
			irq_enable <= 1'b0;
		end else if (wr && (wb_adr == cpu_bus_pkg::REG_CONTROL)) begin
			irq_enable <= wb_dat_w[0];
		end
	end

	// pending flag, a new vblank beats a clear in the same clock
	always_ff @(posedge CLK_6M_IN or negedge rst_n) begin
		if (!rst_n) begin
			irq_pending <= 1'b0;
		end else if (vblank_start) begin
			irq_pending <= 1'b1;
		end else if (wr && (wb_adr == cpu_bus_pkg::REG_STATUS) && wb_dat_w[0]) begin
			irq_pending <= 1'b0;
		end
	end

	// free running, wraps at 16 bits
	always_ff @(posedge CLK_6M_IN or negedge rst_n) begin
		if (!rst_n) begin
			frame_count <= '0;
		end else if (frame_end) begin
			frame_count <= frame_count + 1'b1;
		end
	end

	// position and frame ignore writes
	always_comb begin
		case (wb_adr)
			cpu_bus_pkg::REG_CONTROL: rd_mux = cpu_bus_pkg::bus_data_t'(irq_enable);
			cpu_bus_pkg::REG_STATUS: rd_mux = cpu_bus_pkg::bus_data_t'(irq_pending);
			cpu_bus_pkg::REG_POSITION: rd_mux = cpu_bus_pkg::bus_data_t'(v_count);
			cpu_bus_pkg::REG_FRAME: rd_mux = frame_count;
		endcase
	end

	// read data lands with ack
	always_ff @(posedge CLK_6M_IN) begin
		if (take) begin
			wb_dat_r <= rd_mux;
		end
	end

	assign irq = irq_pending && irq_enable;

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// no ack without a master asking for it
	a_ack_follows_req: assert property (@(posedge CLK_6M_IN) disable iff (!rst_n)
		wb_ack |-> $past(req))
		else $error("ack without a request in the previous clock");

	a_ack_single: assert property (@(posedge CLK_6M_IN) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("ack high on two consecutive clocks");

endmodule

// File: source/v_timing.sv
`timescale 1ns/1ps

module v_timing #(
	parameter int LINES_PER_FRAME = video_timing_pkg::LINES_PER_FRAME,
	parameter int V_VISIBLE_FIRST = video_timing_pkg::V_VISIBLE_FIRST,
	parameter int V_VISIBLE_LAST = video_timing_pkg::V_VISIBLE_LAST,
	parameter int V_SYNC_FIRST = video_timing_pkg::V_SYNC_FIRST,
	parameter int V_SYNC_LAST = video_timing_pkg::V_SYNC_LAST
) (
	input logic CLK_6M_IN,
	input logic rst_n,

	// from the horizontal counter
	input logic line_start,
	input logic line_end,

	// line number
	output video_timing_pkg::v_count_t v_count,

	// active low video timing
	output logic vblank_n,
	output logic vsync_n,
	output logic vreset_n,

	// once per frame events
	output logic vblank_start,
	output logic frame_end
);

	logic last_line;
	logic vbs_seen;
	logic fe_seen;

	assign last_line = (v_count == video_timing_pkg::v_count_t'(LINES_PER_FRAME - 1));

	// advance on the 511 -> 128 edge, wrap after the last line
	always_ff @(posedge CLK_6M_IN or negedge rst_n) begin
		if (!rst_n) begin
			v_count <= '0;
		end else if (line_end) begin
			if (last_line) begin
				v_count <= '0;
			end else begin
				v_count <= v_count + 1'b1;
			end
		end
	end

	// range decodes off the registered line
	assign vblank_n = (v_count >= V_VISIBLE_FIRST) && (v_count <= V_VISIBLE_LAST);
	assign vsync_n = !((v_count >= V_SYNC_FIRST) && (v_count <= V_SYNC_LAST));
	// whole of the last line
	assign vreset_n = !last_line;

	// first clock of the first blank line after the picture
	assign vblank_start = line_start && (v_count == V_VISIBLE_LAST + 1);
	// same edge as the wrap to 0
	assign frame_end = line_end && last_line;

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// remembers an event until the line is over
	always_ff @(posedge CLK_6M_IN or negedge rst_n) begin
		if (!rst_n) begin
			vbs_seen <= 1'b0;
			fe_seen <= 1'b0;
		end else begin
			vbs_seen <= vblank_start || (vbs_seen && !line_end);
			fe_seen <= frame_end || (fe_seen && !line_end);
		end
	end

	a_v_in_frame: assert property (@(posedge CLK_6M_IN) disable iff (!rst_n)
		v_count < LINES_PER_FRAME)
		else $error("v_count left the frame");

	// a second pulse in the same line means the qualifier is broken
	a_vbs_once: assert property (@(posedge CLK_6M_IN) disable iff (!rst_n)
		vblank_start |-> !vbs_seen)
		else $error("two vblank_start pulses within one line");

	a_fe_once: assert property (@(posedge CLK_6M_IN) disable iff (!rst_n)
		frame_end |-> !fe_seen)
		else $error("two frame_end pulses within one line");

endmodule

// File: source/video_timing_pkg.sv
package video_timing_pkg;

	////////////////////////////////////////////////////////////////////////////
	// counter widths and types
	////////////////////////////////////////////////////////////////////////////

	// both counters stand in for a 9 bit 74'161 chain
	localparam int H_COUNT_W = 9;
	localparam int V_COUNT_W = 9;

	// beam position along the line, 128..511
	typedef logic [H_COUNT_W-1:0] h_count_t;
	// line number within the frame, 0..263
	typedef logic [V_COUNT_W-1:0] v_count_t;

	////////////////////////////////////////////////////////////////////////////
	// horizontal geometry, in pixel clocks
	////////////////////////////////////////////////////////////////////////////

	// reload after 511, so 512 - 128 = 384 clocks per line
	localparam int H_PRELOAD = 128;

	// 288 visible pixels, blank outside
	localparam int H_VISIBLE_FIRST = 144;
	localparam int H_VISIBLE_LAST = 431;

	// 32 clock sync pulse inside the blank
	localparam int H_SYNC_FIRST = 448;
	localparam int H_SYNC_LAST = 479;

	////////////////////////////////////////////////////////////////////////////
	// vertical geometry, in lines
	////////////////////////////////////////////////////////////////////////////

	localparam int LINES_PER_FRAME = 264;

	// 224 visible lines
	localparam int V_VISIBLE_FIRST = 16;
	localparam int V_VISIBLE_LAST = 239;

	// four line sync
	localparam int V_SYNC_FIRST = 244;
	localparam int V_SYNC_LAST = 247;

endpackage

// File: source/video_timing_top.sv
`timescale 1ns/1ps

module video_timing_top #(
	// horizontal geometry
	parameter int H_PRELOAD = video_timing_pkg::H_PRELOAD,
	parameter int H_VISIBLE_FIRST = video_timing_pkg::H_VISIBLE_FIRST,
	parameter int H_VISIBLE_LAST = video_timing_pkg::H_VISIBLE_LAST,
	parameter int H_SYNC_FIRST = video_timing_pkg::H_SYNC_FIRST,
	parameter int H_SYNC_LAST = video_timing_pkg::H_SYNC_LAST,
	// vertical geometry
	parameter int LINES_PER_FRAME = video_timing_pkg::LINES_PER_FRAME,
	parameter int V_VISIBLE_FIRST = video_timing_pkg::V_VISIBLE_FIRST,
	parameter int V_VISIBLE_LAST = video_timing_pkg::V_VISIBLE_LAST,
	parameter int V_SYNC_FIRST = video_timing_pkg::V_SYNC_FIRST,
	parameter int V_SYNC_LAST = video_timing_pkg::V_SYNC_LAST
) (
	input logic CLK_6M_IN,
	input logic rst_n,

	// cpu side
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input cpu_bus_pkg::bus_addr_t wb_adr,
	input cpu_bus_pkg::bus_data_t wb_dat_w,
	output cpu_bus_pkg::bus_data_t wb_dat_r,
	output logic wb_ack,
	output logic irq,

	// video side
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank_n,
	output logic vblank_n,
	output logic hreset_n,
	output logic vreset_n,
	output logic strobe_1h,
	output logic strobe_2h,
	output logic strobe_4h,
	output video_timing_pkg::h_count_t h_count,
	output video_timing_pkg::v_count_t v_count
);

	// line and frame events between the blocks
	logic line_start;
	logic line_end;
	logic vblank_start;
	logic frame_end;

	h_timing #(
		.H_PRELOAD(H_PRELOAD),
		.H_VISIBLE_FIRST(H_VISIBLE_FIRST),
		.H_VISIBLE_LAST(H_VISIBLE_LAST),
		.H_SYNC_FIRST(H_SYNC_FIRST),
		.H_SYNC_LAST(H_SYNC_LAST)
	) u_h_timing (
		.CLK_6M_IN(CLK_6M_IN),
		.rst_n(rst_n),
		.h_count(h_count),
		.line_start(line_start),
		.line_end(line_end),
		.hblank_n(hblank_n),
		.hsync_n(hsync_n),
		.hreset_n(hreset_n),
		.strobe_1h(strobe_1h),
		.strobe_2h(strobe_2h),
		.strobe_4h(strobe_4h)
	);

	v_timing #(
		.LINES_PER_FRAME(LINES_PER_FRAME),
		.V_VISIBLE_FIRST(V_VISIBLE_FIRST),
		.V_VISIBLE_LAST(V_VISIBLE_LAST),
		.V_SYNC_FIRST(V_SYNC_FIRST),
		.V_SYNC_LAST(V_SYNC_LAST)
	) u_v_timing (
		.CLK_6M_IN(CLK_6M_IN),
		.rst_n(rst_n),
		.line_start(line_start),
		.line_end(line_end),
		.v_count(v_count),
		.vblank_n(vblank_n),
		.vsync_n(vsync_n),
		.vreset_n(vreset_n),
		.vblank_start(vblank_start),
		.frame_end(frame_end)
	);

	// register block sees the line number and the frame events
	timing_regs u_timing_regs (
		.CLK_6M_IN(CLK_6M_IN),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.v_count(v_count),
		.vblank_start(vblank_start),
		.frame_end(frame_end),
		.irq(irq)
	);

endmodule

// File: verification/tb_tasks.svh
////////////////////////////////////////////////////////////////////////////
// condition waits
////////////////////////////////////////////////////////////////////////////

// signals a wait can watch
typedef enum int {
	WATCH_IRQ,
	WATCH_HRESET_N,
	WATCH_VRESET_N
} watch_t;

function automatic logic watched(input watch_t which);
	case (which)
		WATCH_IRQ: return irq;
		WATCH_HRESET_N: return hreset_n;
		WATCH_VRESET_N: return vreset_n;
		default: return 1'bx;
	endcase
endfunction

// polls on the falling edge, where outputs are settled
task automatic wait_cycles_until(input watch_t which, input logic level, input int limit,
	input string what);
	int n;
	n = 0;
	@(negedge CLK_6M_IN);
	while ((watched(which) !== level) && (n < limit)) begin
		n++;
		@(negedge CLK_6M_IN);
	end
	if (watched(which) !== level) begin
		$display("timeout in %s after %0d clocks waiting for %s", current_test, limit, what);
		abort_run();
	end
endtask

////////////////////////////////////////////////////////////////////////////
// wishbone master
////////////////////////////////////////////////////////////////////////////

// request held until ack, dropped on the next rising edge
task automatic wb_write(input cpu_bus_pkg::bus_addr_t adr, input cpu_bus_pkg::bus_data_t data);
	int n;
	@(posedge CLK_6M_IN);
	wb_cyc <= 1'b1;
	wb_stb <= 1'b1;
	wb_we <= 1'b1;
	wb_adr <= adr;
	wb_dat_w <= data;
	n = 0;
	@(negedge CLK_6M_IN);
	while ((wb_ack !== 1'b1) && (n < ACK_LIMIT)) begin
		n++;
		@(negedge CLK_6M_IN);
	end
	if (wb_ack === 1'b1) begin
		@(posedge CLK_6M_IN);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	end else begin
		$display("no ack in %s for a write to register %0d", current_test, adr);
		abort_run();
	end
endtask

// read data is taken in the ack cycle
task automatic wb_read(input cpu_bus_pkg::bus_addr_t adr, output cpu_bus_pkg::bus_data_t data);
	int n;
	@(posedge CLK_6M_IN);
	wb_cyc <= 1'b1;
	wb_stb <= 1'b1;
	wb_we <= 1'b0;
	wb_adr <= adr;
	n = 0;
	@(negedge CLK_6M_IN);
	while ((wb_ack !== 1'b1) && (n < ACK_LIMIT)) begin
		n++;
		@(negedge CLK_6M_IN);
	end
	if (wb_ack === 1'b1) begin
		data = wb_dat_r;
		@(posedge CLK_6M_IN);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	end else begin
		data = 'x;
		$display("no ack in %s for a read of register %0d", current_test, adr);
		abort_run();
	end
endtask

////////////////////////////////////////////////////////////////////////////
// compares
////////////////////////////////////////////////////////////////////////////

task automatic check_count(input string what, input video_timing_pkg::h_count_t expected,
	input video_timing_pkg::h_count_t actual);
	if (actual !== expected) begin
		$display("ERR %s %s expected %0d actual %0d", current_test, what, expected, actual);
		abort_run();
	end
endtask

task automatic check_line(input string what, input video_timing_pkg::v_count_t expected,
	input video_timing_pkg::v_count_t actual);
	if (actual !== expected) begin
		$display("ERR %s %s expected %0d actual %0d", current_test, what, expected, actual);
		abort_run();
	end
endtask

task automatic check_data(input string what, input cpu_bus_pkg::bus_data_t expected,
	input cpu_bus_pkg::bus_data_t actual);
	if (actual !== expected) begin
		$display("ERR %s %s expected 'h%04h actual 'h%04h", current_test, what, expected,
			actual);
		abort_run();
	end
endtask

task automatic check_bit(input string what, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("ERR %s %s expected %b actual %b", current_test, what, expected, actual);
		abort_run();
	end
endtask

// File: verification/tb_video_timing.sv
`timescale 1ns/1ps

module tb_video_timing;

	// raster figures of the board, 384 clocks by 264 lines
	localparam int LINE_CLOCKS = 384;
	localparam int FRAME_LINES = 264;
	localparam int FRAME_CLOCKS = LINE_CLOCKS * FRAME_LINES;
	// slave answers on the next clock, a little slack
	localparam int ACK_LIMIT = 8;

	logic CLK_6M_IN;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	cpu_bus_pkg::bus_addr_t wb_adr;
	cpu_bus_pkg::bus_data_t wb_dat_w;
	cpu_bus_pkg::bus_data_t wb_dat_r;
	logic wb_ack;
	logic irq;
	logic hsync_n;
	logic vsync_n;
	logic hblank_n;
	logic vblank_n;
	logic hreset_n;
	logic vreset_n;
	logic strobe_1h;
	logic strobe_2h;
	logic strobe_4h;
	video_timing_pkg::h_count_t h_count;
	video_timing_pkg::v_count_t v_count;

	// name shown on error lines
	string current_test;

	video_timing_top UUT (
		.CLK_6M_IN(CLK_6M_IN),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.irq(irq),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.hblank_n(hblank_n),
		.vblank_n(vblank_n),
		.hreset_n(hreset_n),
		.vreset_n(vreset_n),
		.strobe_1h(strobe_1h),
		.strobe_2h(strobe_2h),
		.strobe_4h(strobe_4h),
		.h_count(h_count),
		.v_count(v_count)
	);

	// 4 ns pixel clock
	initial begin
		CLK_6M_IN = 1'b0;
		forever #2 CLK_6M_IN = ~CLK_6M_IN;
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_tasks.svh"

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	// outputs idle, counters at their start values
	task automatic test_reset_state();
		current_test = "reset_state";
		check_bit("hsync_n", 1'b1, hsync_n);
		check_bit("vsync_n", 1'b1, vsync_n);
		check_bit("hreset_n", 1'b1, hreset_n);
		check_bit("irq", 1'b0, irq);
		check_bit("wb_ack", 1'b0, wb_ack);
		check_bit("hblank_n", 1'b0, hblank_n);
		check_bit("vblank_n", 1'b0, vblank_n);
		check_count("h_count", video_timing_pkg::h_count_t'(128), h_count);
		check_line("v_count", video_timing_pkg::v_count_t'(0), v_count);
	endtask

	// one line, from hreset pulse to hreset pulse
	task automatic test_horizontal();
		int clocks;
		int visible;
		int sync_low;
		video_timing_pkg::h_count_t sync_at;
		logic sync_found;
		current_test = "horizontal";
		clocks = 0;
		visible = 0;
		sync_low = 0;
		sync_at = '0;
		sync_found = 1'b0;
		wait_cycles_until(WATCH_HRESET_N, 1'b0, LINE_CLOCKS + 8, "hreset_n low");
		do begin
			@(negedge CLK_6M_IN);
			clocks++;
			if (hblank_n) begin
				visible++;
			end
			if (!hsync_n) begin
				if (!sync_found) begin
					sync_at = h_count;
				end
				sync_found = 1'b1;
				sync_low++;
			end
		end while (hreset_n && (clocks < 2 * LINE_CLOCKS));
		if (hreset_n) begin
			$display("hreset_n did not pulse again within two lines");
			abort_run();
		end else begin
			check_count("clocks per line", video_timing_pkg::h_count_t'(LINE_CLOCKS),
				video_timing_pkg::h_count_t'(clocks));
			check_count("visible clocks", video_timing_pkg::h_count_t'(288),
				video_timing_pkg::h_count_t'(visible));
			check_count("sync clocks", video_timing_pkg::h_count_t'(32),
				video_timing_pkg::h_count_t'(sync_low));
			check_count("first sync position", video_timing_pkg::h_count_t'(448), sync_at);
		end
	endtask

	// strobes against a model of the beam position, from the start of a line
	task automatic test_strobes();
		int n;
		int pos;
		int last_4h;
		int count_4h;
		current_test = "strobes";
		last_4h = -1;
		count_4h = 0;
		// next clock holds the preload value
		wait_cycles_until(WATCH_HRESET_N, 1'b0, LINE_CLOCKS + 8, "hreset_n low");
		for (n = 0; n < 64; n++) begin
			@(negedge CLK_6M_IN);
			pos = 128 + n;
			check_count("h_count", video_timing_pkg::h_count_t'(pos), h_count);
			check_bit("strobe_1h", (pos % 8) == 1, strobe_1h);
			check_bit("strobe_2h", (pos % 8) == 2, strobe_2h);
			check_bit("strobe_4h", (pos % 8) == 4, strobe_4h);
			if (strobe_4h) begin
				if (last_4h >= 0) begin
					check_count("strobe_4h spacing", video_timing_pkg::h_count_t'(8),
						video_timing_pkg::h_count_t'(n - last_4h));
				end
				last_4h = n;
				count_4h++;
			end
		end
		check_count("strobe_4h pulses", video_timing_pkg::h_count_t'(8),
			video_timing_pkg::h_count_t'(count_4h));
	endtask

	// one frame, sampled once per line at the hreset pulse
	task automatic test_vertical();
		int clocks;
		int lines;
		int visible_lines;
		int sync_lines;
		int reset_clocks;
		video_timing_pkg::v_count_t sync_first;
		video_timing_pkg::v_count_t reset_line;
		logic sync_found;
		logic frame_done;
		current_test = "vertical";
		clocks = 0;
		lines = 0;
		visible_lines = 0;
		sync_lines = 0;
		reset_clocks = 0;
		sync_first = '0;
		reset_line = '0;
		sync_found = 1'b0;
		frame_done = 1'b0;
		// line up on the end of the last line
		wait_cycles_until(WATCH_VRESET_N, 1'b0, FRAME_CLOCKS + LINE_CLOCKS, "vreset_n low");
		wait_cycles_until(WATCH_HRESET_N, 1'b0, LINE_CLOCKS + 8, "end of the last line");
		while (!frame_done && (clocks < FRAME_CLOCKS + LINE_CLOCKS)) begin
			@(negedge CLK_6M_IN);
			clocks++;
			// vreset_n covers the whole last line and nothing else
			if (!vreset_n) begin
				reset_clocks++;
			end
			if (!hreset_n) begin
				check_line("line order", video_timing_pkg::v_count_t'(lines), v_count);
				lines++;
				if (vblank_n) begin
					visible_lines++;
				end
				if (!vsync_n) begin
					if (!sync_found) begin
						sync_first = v_count;
					end
					sync_found = 1'b1;
					sync_lines++;
				end
				if (!vreset_n) begin
					reset_line = v_count;
					frame_done = 1'b1;
				end
			end
		end
		if (!frame_done) begin
			$display("vreset_n did not come back within one frame");
			abort_run();
		end else begin
			check_line("lines per frame", video_timing_pkg::v_count_t'(FRAME_LINES),
				video_timing_pkg::v_count_t'(lines));
			check_line("visible lines", video_timing_pkg::v_count_t'(224),
				video_timing_pkg::v_count_t'(visible_lines));
			check_line("sync lines", video_timing_pkg::v_count_t'(4),
				video_timing_pkg::v_count_t'(sync_lines));
			check_line("first sync line", video_timing_pkg::v_count_t'(244), sync_first);
			check_count("vreset clocks", video_timing_pkg::h_count_t'(LINE_CLOCKS),
				video_timing_pkg::h_count_t'(reset_clocks));
			check_line("vreset line", video_timing_pkg::v_count_t'(263), reset_line);
		end
	endtask

	// control readback, position and read only registers
	task automatic test_registers();
		cpu_bus_pkg::bus_data_t wdata;
		cpu_bus_pkg::bus_data_t rdata;
		cpu_bus_pkg::bus_data_t first_pos;
		cpu_bus_pkg::bus_data_t frame_before;
		video_timing_pkg::v_count_t line_now;
		current_test = "registers";
		wdata = cpu_bus_pkg::bus_data_t'($urandom);
		wb_write(cpu_bus_pkg::REG_CONTROL, wdata);
		wb_read(cpu_bus_pkg::REG_CONTROL, rdata);
		// only bit 0 is stored
		check_data("control readback", cpu_bus_pkg::bus_data_t'(wdata[0]), rdata);
		// first clock of a fresh line, room for all accesses below
		wait_cycles_until(WATCH_HRESET_N, 1'b0, LINE_CLOCKS + 8, "hreset_n low");
		wait_cycles_until(WATCH_HRESET_N, 1'b1, 8, "hreset_n high");
		line_now = v_count;
		wb_read(cpu_bus_pkg::REG_POSITION, first_pos);
		wb_read(cpu_bus_pkg::REG_POSITION, rdata);
		check_data("position first read", cpu_bus_pkg::bus_data_t'(line_now), first_pos);
		check_data("position second read", first_pos, rdata);
		wb_read(cpu_bus_pkg::REG_FRAME, frame_before);
		wb_write(cpu_bus_pkg::REG_POSITION, cpu_bus_pkg::bus_data_t'($urandom));
		wb_write(cpu_bus_pkg::REG_FRAME, cpu_bus_pkg::bus_data_t'($urandom));
		wb_read(cpu_bus_pkg::REG_POSITION, rdata);
		check_data("position after write", cpu_bus_pkg::bus_data_t'(line_now), rdata);
		wb_read(cpu_bus_pkg::REG_FRAME, rdata);
		check_data("frame after write", frame_before, rdata);
	endtask

	// vblank interrupt, clear, frame step and masking
	task automatic test_interrupt();
		cpu_bus_pkg::bus_data_t rdata;
		cpu_bus_pkg::bus_data_t frame_first;
		int n;
		current_test = "interrupt";
		// drop anything left pending by the earlier frames
		wb_write(cpu_bus_pkg::REG_STATUS, 16'h0001);
		wb_write(cpu_bus_pkg::REG_CONTROL, 16'h0001);
		wait_cycles_until(WATCH_IRQ, 1'b1, FRAME_CLOCKS + LINE_CLOCKS, "first irq");
		wb_read(cpu_bus_pkg::REG_POSITION, rdata);
		check_data("position at irq", 16'd240, rdata);
		wb_read(cpu_bus_pkg::REG_FRAME, frame_first);
		wb_write(cpu_bus_pkg::REG_STATUS, 16'h0001);
		@(negedge CLK_6M_IN);
		check_bit("irq after clear", 1'b0, irq);
		wb_read(cpu_bus_pkg::REG_STATUS, rdata);
		check_data("status after clear", 16'h0000, rdata);
		wait_cycles_until(WATCH_IRQ, 1'b1, FRAME_CLOCKS + LINE_CLOCKS, "second irq");
		wb_read(cpu_bus_pkg::REG_FRAME, rdata);
		check_data("frame count step", frame_first + 16'd1, rdata);
		// masked, pending still collects the next vblank
		wb_write(cpu_bus_pkg::REG_CONTROL, 16'h0000);
		wb_write(cpu_bus_pkg::REG_STATUS, 16'h0001);
		for (n = 0; n < FRAME_CLOCKS; n++) begin
			@(negedge CLK_6M_IN);
			check_bit("irq while disabled", 1'b0, irq);
		end
		wb_read(cpu_bus_pkg::REG_STATUS, rdata);
		check_data("status after masked vblank", 16'h0001, rdata);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(67));
		current_test = "setup";
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		// two clocks of reset
		repeat (2) @(posedge CLK_6M_IN);
		rst_n <= 1'b1;
		@(negedge CLK_6M_IN);
		test_reset_state();
		test_horizontal();
		test_strobes();
		test_vertical();
		test_registers();
		test_interrupt();
		$display("PASS: all tests");
		$finish;
	end

endmodule
